// File: i2s_rx_top.f
src/i2s_pkg.sv
src/rx_bus_pkg.sv
src/i2s_deserializer.sv
src/sync_word_detector.sv
src/rx_entry_packer.sv
src/rx_sample_fifo.sv
src/apb_rx_regs.sv
src/i2s_rx_top.sv
verif/i2s_rx_assert.sv
verif/i2s_rx_tb.sv

// File: verif/i2s_rx_tb.sv
`timescale 1ns/1ns

module i2s_rx_tb;

	import i2s_pkg::*;
	import rx_bus_pkg::*;

	localparam int clk_ns = 10;
	localparam int bclk_ns = 80;
	localparam int slot_bits = 32;
	localparam int frame_ns = 2 * slot_bits * bclk_ns;
	// frames sent by all tests together.
	localparam int total_frames = 23;
	localparam int margin_ns = 30000;
	localparam logic [stream_id_width-1:0] test_sid = 5'h0b;

	logic clk;
	logic rst_n;
	logic bclk;
	logic lrclk;
	logic sdata;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;
	int err_cnt;
	sample_t sent_q[$];

	i2s_rx_top i_dut (
		.clk(clk),
		.rst_n(rst_n),
		.bclk(bclk),
		.lrclk(lrclk),
		.sdata(sdata),
		.apb_req(apb_req),
		.apb_rsp(apb_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_ns / 2) clk = ~clk;
	end

	initial begin
		#(total_frames * frame_ns + margin_ns);
		$display("watchdog expired before the tests completed");
		$display("Errors found");
		$finish;
	end

	// ----------------------------------------
	// expected values and compares
	// ----------------------------------------

	function automatic fifo_entry_u sample_entry(input sample_t s, input logic [4:0] sid);
		fifo_entry_u e;
		e = '0;
		e.sample.kind = 1'b0;
		e.sample.channel = s.channel;
		e.sample.stream_id = sid;
		e.sample.data = s.data;
		return e;
	endfunction

	function automatic fifo_entry_u marker_entry(input logic [7:0] count);
		fifo_entry_u e;
		e = '0;
		e.marker.kind = 1'b1;
		e.marker.sync_count = count;
		return e;
	endfunction

	function automatic status_t make_status(input logic lck, input logic emp, input logic ful,
			input logic ovf, input logic udf, input level_t lvl);
		status_t s;
		s.locked = lck;
		s.empty = emp;
		s.full = ful;
		s.overflow = ovf;
		s.underflow = udf;
		s.level = lvl;
		return s;
	endfunction

	function automatic logic [31:0] ctrl_word(input logic en, input logic [4:0] sid,
			input logic rearm);
		return {23'b0, rearm, 2'b0, sid, en};
	endfunction

	task automatic check_entry(input fifo_entry_u exp, input fifo_entry_u got, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t ns %s: expected %h, read %h", $time, what, exp, got);
			err_cnt++;
		end
	endtask

	task automatic check_status(input status_t exp, input status_t got, input string what);
		if (got !== exp) begin
			$display("[FAIL] %0t ns %s: expected %h, read %h", $time, what, exp, got);
			err_cnt++;
		end
	endtask

	// CTRL keeps enable in bit 0 and stream_id in bits 5:1, every other bit reads 0.
	task automatic check_ctrl(input ctrl_t exp, input logic [31:0] got, input string what);
		logic [31:0] exp_word;
		exp_word = {26'b0, exp.stream_id, exp.enable};
		if (got !== exp_word) begin
			$display("[FAIL] %0t ns %s: expected %h, read %h", $time, what, exp_word, got);
			err_cnt++;
		end
	endtask

	task automatic check_rsp(input apb_rsp_t exp, input apb_rsp_t got, input string what);
		if (got.pslverr !== exp.pslverr) begin
			$display("[FAIL] %0t ns %s: expected pslverr %b, read %b", $time, what,
				exp.pslverr, got.pslverr);
			err_cnt++;
		end
	endtask

	// ----------------------------------------
	// APB and I2S drivers
	// ----------------------------------------

	task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
			output apb_rsp_t rsp);
		@(posedge clk);
		#1;
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = wr;
		apb_req.paddr = addr;
		apb_req.pwdata = wdata;
		@(posedge clk);
		#1;
		apb_req.penable = 1'b1;
		#4;
		rsp = apb_rsp;
		if (rsp.pready !== 1'b1) begin
			$display("pready stayed low in the access cycle to address %h at %0t ns", addr, $time);
			err_cnt++;
		end
		@(posedge clk);
		#1;
		apb_req = '0;
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata);
		apb_rsp_t rsp;
		apb_access(1'b1, addr, wdata, rsp);
		check_rsp('0, rsp, "write response");
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata);
		apb_rsp_t rsp;
		apb_access(1'b0, addr, 32'h0, rsp);
		check_rsp('0, rsp, "read response");
		rdata = rsp.prdata;
	endtask

	task automatic read_status(output status_t st);
		logic [31:0] word;
		apb_read(addr_status, word);
		st = word[$bits(status_t)-1:0];
	endtask

	// polls STATUS until the FIFO holds the expected number of entries.
	task automatic wait_level(input level_t exp_level);
		status_t st;
		int polls;
		polls = 0;
		read_status(st);
		while (st.level !== exp_level && polls < 50) begin
			read_status(st);
			polls++;
		end
		if (st.level !== exp_level) begin
			$display("FIFO level never reached %0d, it stayed at %0d", exp_level, st.level);
			err_cnt++;
		end
	endtask

	// the MSB goes out on the second bclk of the slot, as I2S places it.
	task automatic send_slot(input logic channel, input logic [23:0] data);
		for (int i = 0; i < slot_bits; i++) begin
			repeat (bclk_ns / (2 * clk_ns)) @(posedge clk);
			#1;
			bclk = 1'b0;
			if (i == 0) begin
				lrclk = channel;
			end
			sdata = (i >= 1 && i <= 24) ? data[24 - i] : 1'b0;
			repeat (bclk_ns / (2 * clk_ns)) @(posedge clk);
			#1;
			bclk = 1'b1;
		end
	endtask

	task automatic send_frame(input logic [23:0] left, input logic [23:0] right);
		send_slot(1'b0, left);
		sent_q.push_back('{1'b1, 1'b0, left});
		send_slot(1'b1, right);
		sent_q.push_back('{1'b1, 1'b1, right});
	endtask

	task automatic send_random_frames(input int count);
		for (int i = 0; i < count; i++) begin
			send_frame(24'($urandom()), 24'($urandom()));
		end
	endtask

	// an lrclk edge with bclk idle closes the last right slot.
	task automatic end_burst();
		repeat (bclk_ns / (2 * clk_ns)) @(posedge clk);
		#1;
		lrclk = 1'b0;
		repeat (8) @(posedge clk);
	endtask

	task automatic send_pattern();
		send_frame({16'($urandom()), 8'h03}, 24'h2b842f);
		send_frame(24'h4042dd, 24'ha1770b);
		end_burst();
	endtask

	task automatic check_samples(input int count);
		logic [31:0] word;
		for (int i = 0; i < count; i++) begin
			apb_read(addr_data, word);
			check_entry(sample_entry(sent_q[i], test_sid), word, "sample entry");
		end
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------

	task automatic test_reset();
		status_t st;
		logic [31:0] word;
		read_status(st);
		check_status(make_status(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0), st, "status after reset");
		apb_read(addr_ctrl, word);
		check_ctrl('0, word, "ctrl after reset");
	endtask

	task automatic test_prelock_discard();
		status_t st;
		apb_write(addr_ctrl, ctrl_word(1'b1, test_sid, 1'b0));
		send_random_frames(4);
		end_burst();
		repeat (10) @(posedge clk);
		read_status(st);
		check_status(make_status(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0), st, "status before lock");
	endtask

	task automatic test_lock_and_stream();
		status_t st;
		logic [31:0] word;
		send_pattern();
		wait_level(5'd1);
		read_status(st);
		check_status(make_status(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 5'd1), st, "status at lock");
		apb_read(addr_data, word);
		check_entry(marker_entry(8'd1), word, "first marker");
		sent_q.delete();
		send_random_frames(3);
		end_burst();
		wait_level(5'd6);
		check_samples(6);
	endtask

	task automatic test_overflow();
		status_t st;
		sent_q.delete();
		send_random_frames(10);
		end_burst();
		wait_level(5'd16);
		read_status(st);
		check_status(make_status(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 5'd16), st, "status when full");
		check_samples(16);
		apb_write(addr_status, 32'h0);
		read_status(st);
		check_status(make_status(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0), st, "status after clear");
	endtask

	task automatic test_underflow_and_decode();
		status_t st;
		apb_rsp_t rsp;
		apb_rsp_t exp_rsp;
		logic [31:0] word;
		apb_read(addr_data, word);
		check_entry('0, word, "pop of empty FIFO");
		read_status(st);
		check_status(make_status(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 5'd0), st, "status on underflow");
		exp_rsp = '0;
		exp_rsp.pslverr = 1'b1;
		apb_access(1'b0, 4'hc, 32'h0, rsp);
		check_rsp(exp_rsp, rsp, "read of unmapped address");
		apb_write(addr_status, 32'h0);
	endtask

	task automatic test_rearm();
		status_t st;
		logic [31:0] word;
		apb_write(addr_ctrl, ctrl_word(1'b1, test_sid, 1'b1));
		apb_read(addr_ctrl, word);
		check_ctrl('{1'b1, test_sid}, word, "ctrl after rearm");
		send_random_frames(2);
		end_burst();
		repeat (10) @(posedge clk);
		read_status(st);
		check_status(make_status(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0), st, "status after rearm");
		send_pattern();
		wait_level(5'd1);
		apb_read(addr_data, word);
		check_entry(marker_entry(8'd2), word, "second marker");
		read_status(st);
		check_status(make_status(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 5'd0), st, "status at relock");
	endtask

	initial begin
		void'($urandom(2));
		rst_n = 1'b0;
		bclk = 1'b1;
		lrclk = 1'b0;
		sdata = 1'b0;
		apb_req = '0;
		err_cnt = 0;
		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset();
		test_prelock_discard();
		test_lock_and_stream();
		test_overflow();
		test_underflow_and_decode();
		test_rearm();
		$display("errors: %0d", err_cnt);
		if (err_cnt == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: verif/i2s_rx_assert.sv
`timescale 1ns/1ns

module i2s_rx_assert (
	input logic clk,
	input logic rst_n,
	input rx_bus_pkg::apb_req_t apb_req,
	input rx_bus_pkg::apb_rsp_t apb_rsp,
	input logic full,
	input logic empty,
	input logic push
);

	// pready only answers the access cycle of a transfer.
	pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
		apb_rsp.pready |-> (apb_req.psel && apb_req.penable))
		else $error("pready high outside an APB access cycle");

	fifo_state_valid: assert property (@(posedge clk) disable iff (!rst_n)
		!(full && empty))
		else $error("FIFO reports full and empty together");

	// the pipeline leaves reset with nothing queued for the FIFO.
	no_push_after_reset: assert property (@(posedge clk) !rst_n |=> !push)
		else $error("push high in the cycle after reset");

endmodule

bind i2s_rx_top i2s_rx_assert i_assert (
	.clk(clk),
	.rst_n(rst_n),
	.apb_req(apb_req),
	.apb_rsp(apb_rsp),
	.full(full),
	.empty(empty),
	.push(push)
);

// File: src/i2s_rx_top.sv
`timescale 1ns/1ns

module i2s_rx_top (
	input logic clk,
	input logic rst_n,
	input logic bclk,
	input logic lrclk,
	input logic sdata,
	input rx_bus_pkg::apb_req_t apb_req,
	output rx_bus_pkg::apb_rsp_t apb_rsp
);

	import i2s_pkg::*;
	import rx_bus_pkg::*;

	sample_t deser_sample;
	sample_t det_sample;
	logic match;
	logic locked;
	fifo_entry_u entry;
	logic push;
	fifo_entry_u head;
	level_t level;
	logic full;
	logic empty;
	logic overflow;
	logic underflow;
	logic enable;
	logic [stream_id_width-1:0] stream_id;
	logic rearm;
	logic pop;
	logic clear_flags;

	i2s_deserializer i_deser (
		.clk(clk),
		.rst_n(rst_n),
		.enable(enable),
		.bclk(bclk),
		.lrclk(lrclk),
		.sdata(sdata),
		.sample(deser_sample)
	);

	sync_word_detector i_detect (
		.clk(clk),
		.rst_n(rst_n),
		.rearm(rearm),
		.sample_in(deser_sample),
		.sample_out(det_sample),
		.match(match),
		.locked(locked)
	);

	rx_entry_packer i_pack (
		.clk(clk),
		.rst_n(rst_n),
		.stream_id(stream_id),
		.sample(det_sample),
		.match(match),
		.entry(entry),
		.push(push)
	);

	rx_sample_fifo i_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push(push),
		.wr_entry(entry),
		.pop(pop),
		.clear_flags(clear_flags),
		.head(head),
		.level(level),
		.full(full),
		.empty(empty),
		.overflow(overflow),
		.underflow(underflow)
	);

	apb_rx_regs i_regs (
		.clk(clk),
		.rst_n(rst_n),
		.req(apb_req),
		.rsp(apb_rsp),
		.enable(enable),
		.stream_id(stream_id),
		.rearm(rearm),
		.pop(pop),
		.clear_flags(clear_flags),
		.head(head),
		.level(level),
		.full(full),
		.empty(empty),
		.overflow(overflow),
		.underflow(underflow),
		.locked(locked)
	);

endmodule

// File: src/apb_rx_regs.sv
`timescale 1ns/1ns

module apb_rx_regs (
	input logic clk,
	input logic rst_n,
	input rx_bus_pkg::apb_req_t req,
	output rx_bus_pkg::apb_rsp_t rsp,
	output logic enable,
	output logic [rx_bus_pkg::stream_id_width-1:0] stream_id,
	output logic rearm,
	output logic pop,
	output logic clear_flags,
	input rx_bus_pkg::fifo_entry_u head,
	input rx_bus_pkg::level_t level,
	input logic full,
	input logic empty,
	input logic overflow,
	input logic underflow,
	input logic locked
);

	import rx_bus_pkg::*;

	ctrl_t ctrl;
	status_t status;
	logic access;
	logic wr_access;
	logic rd_access;

	// no wait states, so the access cycle is also the completing cycle.
	assign access = req.psel & req.penable;
	assign wr_access = access & req.pwrite;
	assign rd_access = access & ~req.pwrite;

	assign status = '{locked, empty, full, overflow, underflow, level};

	// ----------------------------------------
	// write side
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ctrl <= '0;
		end else if (wr_access && req.paddr == addr_ctrl) begin
			ctrl.enable <= req.pwdata[0];
			ctrl.stream_id <= req.pwdata[stream_id_width:1];
		end
	end

	// strobes act at the edge that ends the access cycle.
	assign rearm = wr_access && req.paddr == addr_ctrl && req.pwdata[ctrl_rearm_bit];
	assign clear_flags = wr_access && req.paddr == addr_status;
	assign pop = rd_access && req.paddr == addr_data;

	assign enable = ctrl.enable;
	assign stream_id = ctrl.stream_id;

	// ----------------------------------------
	// read side
	// ----------------------------------------

	always_comb begin
		rsp = '0;
		rsp.pready = access;
		case (req.paddr)
			addr_ctrl: rsp.prdata = {{(31 - stream_id_width){1'b0}}, ctrl.stream_id, ctrl.enable};
			addr_status: rsp.prdata = 32'(status);
			addr_data: rsp.prdata = head;
			default: rsp.pslverr = access;
		endcase
	end

endmodule

// File: src/rx_sample_fifo.sv
`timescale 1ns/1ns

module rx_sample_fifo (
	input logic clk,
	input logic rst_n,
	input logic push,
	input rx_bus_pkg::fifo_entry_u wr_entry,
	input logic pop,
	input logic clear_flags,
	output rx_bus_pkg::fifo_entry_u head,
	output rx_bus_pkg::level_t level,
	output logic full,
	output logic empty,
	output logic overflow,
	output logic underflow
);

	import rx_bus_pkg::*;

	fifo_entry_u mem [fifo_depth];
	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;
	logic do_push;
	logic do_pop;

	assign full = (level == level_t'(fifo_depth));
	assign empty = (level == '0);
	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	// pointers wrap naturally since the depth is a power of two.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= wr_entry;
		end
	end

	// a new error in the same cycle as a clear keeps its flag set.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			overflow <= 1'b0;
			underflow <= 1'b0;
		end else begin
			if (clear_flags) begin
				overflow <= 1'b0;
				underflow <= 1'b0;
			end
			if (push && full) begin
				overflow <= 1'b1;
			end
			if (pop && empty) begin
				underflow <= 1'b1;
			end
		end
	end

	assign head = empty ? '0 : mem[rd_ptr];

endmodule

// File: src/rx_entry_packer.sv
`timescale 1ns/1ns

module rx_entry_packer (
	input logic clk,
	input logic rst_n,
	input logic [rx_bus_pkg::stream_id_width-1:0] stream_id,
	input i2s_pkg::sample_t sample,
	input logic match,
	output rx_bus_pkg::fifo_entry_u entry,
	output logic push
);

	import rx_bus_pkg::*;

	logic [sync_count_width-1:0] sync_count;
	fifo_entry_u entry_next;

	// match and a forwarded sample never arrive in the same cycle.
	always_comb begin
		entry_next = '0;
		if (match) begin
			entry_next.marker.kind = kind_marker;
			entry_next.marker.sync_count = sync_count + 1'b1;
		end else begin
			entry_next.sample.kind = kind_sample;
			entry_next.sample.channel = sample.channel;
			entry_next.sample.stream_id = stream_id;
			entry_next.sample.data = sample.data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			push <= 1'b0;
			sync_count <= '0;
		end else begin
			push <= match | sample.valid;
			if (match) begin
				sync_count <= sync_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		entry <= entry_next;
	end

endmodule

// File: src/sync_word_detector.sv
`timescale 1ns/1ns

module sync_word_detector (
	input logic clk,
	input logic rst_n,
	input logic rearm,
	input i2s_pkg::sample_t sample_in,
	output i2s_pkg::sample_t sample_out,
	output logic match,
	output logic locked
);

	import i2s_pkg::*;

	logic [window_width-1:0] window;
	logic [window_width-1:0] window_next;
	logic hit;

	// newest sample enters at the bottom.
	assign window_next = {window[window_width-sample_width-1:0], sample_in.data};
	assign hit = (window_next[sync_width-1:0] == sync_pattern);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			window <= '0;
			locked <= 1'b0;
			match <= 1'b0;
			sample_out <= '0;
		end else if (rearm) begin
			window <= '0;
			locked <= 1'b0;
			match <= 1'b0;
			sample_out.valid <= 1'b0;
		end else begin
			match <= 1'b0;
			// locked is still low for the sample that completes the pattern,
			// so that sample is not forwarded.
			sample_out.valid <= sample_in.valid & locked;
			if (sample_in.valid) begin
				window <= window_next;
				sample_out.channel <= sample_in.channel;
				sample_out.data <= sample_in.data;
				if (!locked && hit) begin
					locked <= 1'b1;
					match <= 1'b1;
				end
			end
		end
	end

endmodule

// File: src/i2s_deserializer.sv
`timescale 1ns/1ns

module i2s_deserializer (
	input logic clk,
	input logic rst_n,
	input logic enable,
	input logic bclk,
	input logic lrclk,
	input logic sdata,
	output i2s_pkg::sample_t sample
);

	import i2s_pkg::*;

	typedef struct packed {
		logic bclk;
		logic lrclk;
		logic sdata;
	} pins_t;

	// counts bclk rising edges since the last lrclk edge, up to at least sample_width + 1.
	localparam int cnt_width = $clog2(sample_width + 2);

	pins_t pins_meta;
	pins_t pins_sync;
	pins_t pins_prev;
	logic bclk_rise;
	logic lr_edge;
	logic armed;
	logic [cnt_width-1:0] bit_cnt;
	logic [sample_width-1:0] shift_data;

	// ----------------------------------------
	// pin synchronizer and edge detect
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pins_meta <= '0;
			pins_sync <= '0;
			pins_prev <= '0;
		end else begin
			pins_meta <= '{bclk, lrclk, sdata};
			pins_sync <= pins_meta;
			pins_prev <= pins_sync;
		end
	end

	assign bclk_rise = pins_sync.bclk & ~pins_prev.bclk;
	assign lr_edge = pins_sync.lrclk ^ pins_prev.lrclk;

	// ----------------------------------------
	// slot framing
	// ----------------------------------------

	// the first rising edge after lrclk moves still carries the previous slot's LSB,
	// so bits are taken from the second edge on.
	always_ff @(posedge clk) begin
		if (lr_edge) begin
			shift_data <= '0;
		end else if (bclk_rise && bit_cnt != '0 && bit_cnt <= sample_width) begin
			shift_data[sample_width - bit_cnt] <= pins_sync.sdata;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bit_cnt <= '0;
			armed <= 1'b0;
			sample <= '0;
		end else begin
			sample.valid <= 1'b0;
			// armed goes high at the first slot boundary seen while enabled.
			if (!enable) begin
				armed <= 1'b0;
			end else if (lr_edge) begin
				armed <= 1'b1;
			end
			if (lr_edge) begin
				sample.valid <= armed & enable;
				sample.channel <= pins_prev.lrclk;
				sample.data <= shift_data;
				bit_cnt <= '0;
			end else if (bclk_rise && bit_cnt != '1) begin
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

endmodule

// File: src/rx_bus_pkg.sv
package rx_bus_pkg;

	// ----------------------------------------
	// FIFO sizing
	// ----------------------------------------

	localparam int fifo_depth = 16;
	localparam int ptr_width = $clog2(fifo_depth);

	// level runs from 0 to fifo_depth inclusive.
	typedef logic [ptr_width:0] level_t;

	// ----------------------------------------
	// APB and register map
	// ----------------------------------------

	localparam int addr_width = 4;
	localparam logic [addr_width-1:0] addr_ctrl = 4'h0;
	localparam logic [addr_width-1:0] addr_status = 4'h4;
	localparam logic [addr_width-1:0] addr_data = 4'h8;

	// writing 1 here in CTRL restarts the sync search.
	localparam int ctrl_rearm_bit = 8;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [addr_width-1:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [31:0] prdata;
		logic pready;
		logic pslverr;
	} apb_rsp_t;

	// ----------------------------------------
	// FIFO entries
	// ----------------------------------------

	localparam int entry_data_width = 24;
	localparam int stream_id_width = 5;
	localparam int sync_count_width = 8;

	localparam logic kind_sample = 1'b0;
	localparam logic kind_marker = 1'b1;

	typedef struct packed {
		logic kind;
		logic channel;
		logic [stream_id_width-1:0] stream_id;
		logic pad;
		logic [entry_data_width-1:0] data;
	} sample_entry_t;

	typedef struct packed {
		logic kind;
		logic [31-sync_count_width-1:0] pad;
		logic [sync_count_width-1:0] sync_count;
	} marker_entry_t;

	// the kind bit sits at the top of both views and selects the decode.
	typedef union packed {
		sample_entry_t sample;
		marker_entry_t marker;
	} fifo_entry_u;

	typedef struct packed {
		logic enable;
		logic [stream_id_width-1:0] stream_id;
	} ctrl_t;

	typedef struct packed {
		logic locked;
		logic empty;
		logic full;
		logic overflow;
		logic underflow;
		level_t level;
	} status_t;

endpackage

// File: src/i2s_pkg.sv
package i2s_pkg;

	// ----------------------------------------
	// audio framing
	// ----------------------------------------

	// bits kept from each channel slot.
	localparam int sample_width = 24;

	// the detector window holds this many samples.
	localparam int window_samples = 4;
	localparam int window_width = sample_width * window_samples;

	// ----------------------------------------
	// sync pattern
	// ----------------------------------------

	localparam int sync_width = 80;

	// first byte on the wire sits in the top byte.
	localparam logic [sync_width-1:0] sync_pattern = 80'h032B_842F_4042_DDA1_770B;

	// one channel sample as it moves down the pipeline.
	// channel is 0 for left (lrclk low) and 1 for right.
	typedef struct packed {
		logic valid;
		logic channel;
		logic [sample_width-1:0] data;
	} sample_t;

endpackage
